// ==== design/issue_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage parameters
// register file size, buffer depth, unit latencies, counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// architectural registers and index width
`define ISSUE_NUM_REGS 32
`define ISSUE_REG_W 5

// entries in the issue buffer
`define ISSUE_BUF_DEPTH 2

// cycles from the issuing edge to the finish cycle
`define ISSUE_ALU_LAT 1
`define ISSUE_MUL_LAT 3

// issued micro-op counter width
`define ISSUE_CNT_W 16

`endif

// ==== design/issue_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage types
// micro-op class and the decoded slot carried through issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

package issue_pkg;

    // which execute resource a micro-op needs
    typedef enum logic [1:0] {
        uop_nop = 2'd0,
        uop_alu = 2'd1,
        uop_mul = 2'd2
    } uop_class_t;

    // one decoded micro-op as offered by fetch
    typedef struct packed {
        logic                    valid;
        uop_class_t              cls;
        // rd of 0 never marks a register busy
        logic [`ISSUE_REG_W-1:0] rd;
        logic [`ISSUE_REG_W-1:0] rj;
        logic [`ISSUE_REG_W-1:0] rk;
        logic [31:0]             imm;
        logic [31:0]             pc;
        // exception code, carried only
        logic [6:0]              exc;
    } issue_slot_t;

endpackage

`default_nettype wire

// ==== design/issue_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue buffer
// two-entry in-order queue between fetch and issue select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_buffer
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  issue_slot_t fetch0,
    input  issue_slot_t fetch1,
    output logic [1:0]  num_read,
    input  logic        eu0_en,
    input  logic        eu1_en,
    output issue_slot_t head0,
    output issue_slot_t head1
);

    logic [1:0]  cnt_q;
    logic [1:0]  cnt_d;
    issue_slot_t ent0_q;
    issue_slot_t ent1_q;
    issue_slot_t ent0_d;
    issue_slot_t ent1_d;
    logic [1:0]  n_out;
    logic [1:0]  occ_left;
    logic [1:0]  free;
    logic [1:0]  occ;

    // occupancy once this cycle's issue has left
    assign n_out    = {1'b0, eu0_en} + {1'b0, eu1_en};
    assign occ_left = cnt_q - n_out;
    assign free     = 2'(`ISSUE_BUF_DEPTH) - occ_left;

    // nothing is taken while flushing
    assign num_read = flush ? 2'd0 : free;

    // drop issued entries, compact, append valid arrivals
    always_comb begin
        ent0_d = (n_out == 2'd1) ? ent1_q : ent0_q;
        ent1_d = ent1_q;
        occ    = occ_left;
        if (num_read != 2'd0 && fetch0.valid) begin
            if (occ == 2'd0) begin
                ent0_d = fetch0;
            end else begin
                ent1_d = fetch0;
            end
            occ = occ + 2'd1;
        end
        // bubbles are consumed but never stored
        if (num_read == 2'd2 && fetch1.valid) begin
            if (occ == 2'd0) begin
                ent0_d = fetch1;
            end else begin
                ent1_d = fetch1;
            end
            occ = occ + 2'd1;
        end
        cnt_d = occ;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= 2'd0;
        end else if (flush) begin
            cnt_q <= 2'd0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    always_ff @(posedge clk) begin
        ent0_q <= ent0_d;
        ent1_q <= ent1_d;
    end

    // valid comes from occupancy, stale entries never look live
    always_comb begin
        head0       = ent0_q;
        head1       = ent1_q;
        head0.valid = (cnt_q != 2'd0);
        head1.valid = (cnt_q == 2'd2);
    end

endmodule

`default_nettype wire

// ==== design/issue_scoreboard.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue scoreboard
// one ready bit per register, finish seen in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_scoreboard (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      eu0_en,
    input  logic                      eu1_en,
    input  logic [`ISSUE_REG_W-1:0]   eu0_rd,
    input  logic [`ISSUE_REG_W-1:0]   eu1_rd,
    input  logic                      fin0,
    input  logic                      fin1,
    input  logic [`ISSUE_REG_W-1:0]   fin0_rd,
    input  logic [`ISSUE_REG_W-1:0]   fin1_rd,
    output logic [`ISSUE_NUM_REGS-1:0] ready_mask
);

    logic [`ISSUE_NUM_REGS-1:0] rdy_q;
    logic [`ISSUE_NUM_REGS-1:0] rdy_fin;
    logic [`ISSUE_NUM_REGS-1:0] rdy_d;

    // finish first, so a consumer can go in its producer's finish cycle
    always_comb begin
        rdy_fin = rdy_q;
        if (fin0) begin
            rdy_fin[fin0_rd] = 1'b1;
        end
        if (fin1) begin
            rdy_fin[fin1_rd] = 1'b1;
        end
    end

    // then mark the new destinations busy, r0 excluded
    always_comb begin
        rdy_d = rdy_fin;
        if (eu0_en && eu0_rd != '0) begin
            rdy_d[eu0_rd] = 1'b0;
        end
        if (eu1_en && eu1_rd != '0) begin
            rdy_d[eu1_rd] = 1'b0;
        end
    end

    assign ready_mask = rdy_fin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdy_q <= '1;
        end else if (flush) begin
            rdy_q <= '1;
        end else begin
            rdy_q <= rdy_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue select
// in-order dual-issue decision for the two buffer heads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_select
    import issue_pkg::*;
(
    input  issue_slot_t                head0,
    input  issue_slot_t                head1,
    input  logic [`ISSUE_NUM_REGS-1:0] ready_mask,
    input  logic                       eu0_ready,
    input  logic                       eu1_ready,
    input  logic                       dual_issue_en,
    output logic                       eu0_en,
    output logic                       eu1_en
);

    logic h0_nop;
    logic h0_ops_ok;
    logic h1_ops_ok;
    logic h1_conflict;
    logic h1_is_alu;

    // a plain nop reads nothing, it only has to retire
    assign h0_nop    = (head0.cls == uop_nop) && (head0.exc == '0);
    assign h0_ops_ok = h0_nop || (ready_mask[head0.rj] && ready_mask[head0.rk]);

    // older slot goes to eu0, both alu and mul
    assign eu0_en = head0.valid && eu0_ready && h0_ops_ok;

    assign h1_ops_ok = ready_mask[head1.rj] && ready_mask[head1.rk];
    assign h1_is_alu = (head1.cls == uop_alu);

    // head1 may not read or rewrite what head0 writes this cycle
    assign h1_conflict = (head0.rd != '0) &&
                         ((head1.rj == head0.rd) ||
                          (head1.rk == head0.rd) ||
                          (head1.rd == head0.rd));

    // younger never passes older, eu1 is alu only
    assign eu1_en = eu0_en &&
                    dual_issue_en &&
                    head1.valid &&
                    h1_is_alu &&
                    eu1_ready &&
                    h1_ops_ok &&
                    !h1_conflict;

endmodule

`default_nettype wire

// ==== design/issue_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue control
// dual-issue enable bit and issued micro-op counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   cfg_we,
    input  logic                   cfg_dual,
    input  logic                   eu0_en,
    input  logic                   eu1_en,
    output logic                   dual_issue_en,
    output logic [`ISSUE_CNT_W-1:0] issued_count
);

    localparam int CNT_W = `ISSUE_CNT_W;

    logic [CNT_W-1:0] n_issued;

    assign n_issued = CNT_W'(eu0_en) + CNT_W'(eu1_en);

    // dual issue on out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dual_issue_en <= 1'b1;
        end else if (cfg_we) begin
            dual_issue_en <= cfg_dual;
        end
    end

    // issues in a flush cycle are killed, so they are not counted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issued_count <= '0;
        end else if (!flush) begin
            issued_count <= issued_count + n_issued;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute unit model
// holds one destination for a fixed latency, then pulses finish
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module exec_unit
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    en,
    input  issue_slot_t             slot,
    output logic                    ready,
    output logic                    finish,
    output logic [`ISSUE_REG_W-1:0] finish_rd
);

    localparam int LAT_W = $clog2(`ISSUE_MUL_LAT + 1);

    logic                    busy_q;
    logic [LAT_W-1:0]        left_q;
    logic [LAT_W-1:0]        lat;
    logic [`ISSUE_REG_W-1:0] rd_q;

    // nops take the alu path
    assign lat = (slot.cls == uop_mul) ? LAT_W'(`ISSUE_MUL_LAT) : LAT_W'(`ISSUE_ALU_LAT);

    // finish in the lat-th cycle after the issuing edge
    assign finish    = busy_q && (left_q == LAT_W'(1));
    assign finish_rd = rd_q;

    // free again in the finish cycle
    assign ready = !busy_q || finish;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            left_q <= '0;
        end else if (flush) begin
            busy_q <= 1'b0;
            left_q <= '0;
        end else if (en) begin
            busy_q <= 1'b1;
            left_q <= lat;
        end else if (busy_q) begin
            busy_q <= !finish;
            left_q <= left_q - LAT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rd_q <= slot.rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage top
// buffer, scoreboard, select and control with two execute units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_top
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    cfg_we,
    input  logic                    cfg_dual,
    input  issue_slot_t             fetch0,
    input  issue_slot_t             fetch1,
    output logic [1:0]              num_read,
    output logic                    eu0_en,
    output logic                    eu1_en,
    output issue_slot_t             eu0_slot,
    output issue_slot_t             eu1_slot,
    output logic                    fin0,
    output logic                    fin1,
    output logic [`ISSUE_REG_W-1:0] fin0_rd,
    output logic [`ISSUE_REG_W-1:0] fin1_rd,
    output logic [`ISSUE_CNT_W-1:0] issued_count
);

    logic [`ISSUE_NUM_REGS-1:0] ready_mask;
    logic                       eu0_ready;
    logic                       eu1_ready;
    logic                       dual_issue_en;

    // the buffer heads are what the units receive
    issue_buffer u_buffer (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .fetch0   (fetch0),
        .fetch1   (fetch1),
        .num_read (num_read),
        .eu0_en   (eu0_en),
        .eu1_en   (eu1_en),
        .head0    (eu0_slot),
        .head1    (eu1_slot)
    );

    issue_scoreboard u_scoreboard (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .eu0_en     (eu0_en),
        .eu1_en     (eu1_en),
        .eu0_rd     (eu0_slot.rd),
        .eu1_rd     (eu1_slot.rd),
        .fin0       (fin0),
        .fin1       (fin1),
        .fin0_rd    (fin0_rd),
        .fin1_rd    (fin1_rd),
        .ready_mask (ready_mask)
    );

    issue_select u_select (
        .head0         (eu0_slot),
        .head1         (eu1_slot),
        .ready_mask    (ready_mask),
        .eu0_ready     (eu0_ready),
        .eu1_ready     (eu1_ready),
        .dual_issue_en (dual_issue_en),
        .eu0_en        (eu0_en),
        .eu1_en        (eu1_en)
    );

    issue_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .cfg_we        (cfg_we),
        .cfg_dual      (cfg_dual),
        .eu0_en        (eu0_en),
        .eu1_en        (eu1_en),
        .dual_issue_en (dual_issue_en),
        .issued_count  (issued_count)
    );

    // eu0 runs alu and mul
    exec_unit u_eu0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .en        (eu0_en),
        .slot      (eu0_slot),
        .ready     (eu0_ready),
        .finish    (fin0),
        .finish_rd (fin0_rd)
    );

    // eu1 only ever gets alu work from select
    exec_unit u_eu1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .en        (eu1_en),
        .slot      (eu1_slot),
        .ready     (eu1_ready),
        .finish    (fin1),
        .finish_rd (fin1_rd)
    );

endmodule

`default_nettype wire

// ==== test/issue_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage testbench
// table-driven fetch model with a reference scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "issue_params.svh"

module issue_tb
    import issue_pkg::*;
();

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    flush;
    logic                    cfg_we;
    logic                    cfg_dual;
    issue_slot_t             fetch0;
    issue_slot_t             fetch1;
    logic [1:0]              num_read;
    logic                    eu0_en;
    logic                    eu1_en;
    issue_slot_t             eu0_slot;
    issue_slot_t             eu1_slot;
    logic                    fin0;
    logic                    fin1;
    logic [`ISSUE_REG_W-1:0] fin0_rd;
    logic [`ISSUE_REG_W-1:0] fin1_rd;
    logic [`ISSUE_CNT_W-1:0] issued_count;

    // stimulus table, programs are slices of it
    issue_slot_t tab [0:63];
    int          ntab = 0;
    int          nprog = 0;
    int          prog_start [0:7];
    int          prog_len [0:7];
    int          prog_flush [0:7];
    logic        prog_dual [0:7];
    logic        built = 1'b0;

    // reference model state
    logic [`ISSUE_NUM_REGS-1:0] rdy = '1;
    logic                       ref_dual = 1'b1;
    int  exp_idx = 0;
    int  fidx = 0;
    int  prog_end = 0;
    int  strobes = 0;
    logic pv0 = 1'b0;
    logic pv1 = 1'b0;
    int  pl0 = 0;
    int  pl1 = 0;
    logic [`ISSUE_REG_W-1:0] prd0 = '0;
    logic [`ISSUE_REG_W-1:0] prd1 = '0;

    issue_top UUT (
        .clk(clk), .arst_n(arst_n), .flush(flush), .cfg_we(cfg_we), .cfg_dual(cfg_dual),
        .fetch0(fetch0), .fetch1(fetch1), .num_read(num_read),
        .eu0_en(eu0_en), .eu1_en(eu1_en), .eu0_slot(eu0_slot), .eu1_slot(eu1_slot),
        .fin0(fin0), .fin1(fin1), .fin0_rd(fin0_rd), .fin1_rd(fin1_rd),
        .issued_count(issued_count)
    );

    always #10 clk = ~clk;

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic begin_prog(input logic dual, input int flush_at);
        prog_start[nprog] = ntab;
        prog_dual[nprog]  = dual;
        prog_flush[nprog] = flush_at;
        nprog = nprog + 1;
    endtask

    // class 0 nop, 1 alu, 2 mul
    task automatic add_uop(input int c, input int dst, input int src_j, input int src_k);
        tab[ntab]       = '0;
        tab[ntab].valid = 1'b1;
        tab[ntab].cls   = uop_class_t'(2'(c));
        tab[ntab].rd    = (c == 0) ? '0 : 5'(dst);
        tab[ntab].rj    = (c == 0) ? 5'($urandom) : 5'(src_j);
        tab[ntab].rk    = (c == 0) ? 5'($urandom) : 5'(src_k);
        tab[ntab].imm   = $urandom;
        tab[ntab].pc    = 32'h1000 + 32'(ntab * 4);
        ntab = ntab + 1;
    endtask

    function automatic int lat_of(input uop_class_t c);
        return (c == uop_mul) ? `ISSUE_MUL_LAT : `ISSUE_ALU_LAT;
    endfunction

    // everything sampled mid-cycle, inputs are stable by then
    task automatic observe_cycle();
        logic [`ISSUE_NUM_REGS-1:0] view;
        logic fe0;
        logic fe1;
        logic clash;
        view = rdy;
        fe0  = pv0 && (pl0 == 1);
        fe1  = pv1 && (pl1 == 1);
        check_eq(128'(fin0), 128'(fe0), "fin0 pulse");
        check_eq(128'(fin1), 128'(fe1), "fin1 pulse");
        if (fe0) begin
            check_eq(128'(fin0_rd), 128'(prd0), "fin0_rd");
            view[prd0] = 1'b1;
        end
        if (fe1) begin
            check_eq(128'(fin1_rd), 128'(prd1), "fin1_rd");
            view[prd1] = 1'b1;
        end
        if (flush) begin
            check_eq(128'(num_read), 128'(0), "num_read during flush");
        end
        if (eu0_en) begin
            check_eq(128'(pv0 && !fe0), 128'(0), "eu0 issued while busy");
            check_eq(128'(exp_idx < prog_end), 128'(1), "eu0 issued past program end");
            check_eq(128'(eu0_slot), 128'(tab[exp_idx]), "eu0 program order");
            if (!(eu0_slot.cls == uop_nop && eu0_slot.exc == '0)) begin
                check_eq(128'(view[eu0_slot.rj] && view[eu0_slot.rk]), 128'(1),
                         "eu0 operands not ready");
            end
        end
        if (eu1_en) begin
            clash = (eu0_slot.rd != '0) && ((eu1_slot.rj == eu0_slot.rd) ||
                    (eu1_slot.rk == eu0_slot.rd) || (eu1_slot.rd == eu0_slot.rd));
            check_eq(128'(eu0_en), 128'(1), "eu1 issued without eu0");
            check_eq(128'(ref_dual), 128'(1), "eu1 issued with dual issue off");
            check_eq(128'(eu1_slot.cls), 128'(uop_alu), "eu1 issued non-alu");
            check_eq(128'(pv1 && !fe1), 128'(0), "eu1 issued while busy");
            check_eq(128'(exp_idx + 1 < prog_end), 128'(1), "eu1 issued past program end");
            check_eq(128'(eu1_slot), 128'(tab[exp_idx + 1]), "eu1 program order");
            check_eq(128'(view[eu1_slot.rj] && view[eu1_slot.rk]), 128'(1),
                     "eu1 operands not ready");
            check_eq(128'(clash), 128'(0), "eu1 conflicts with eu0 rd");
        end
        if (fe0) pv0 = 1'b0;
        else if (pv0) pl0 = pl0 - 1;
        if (fe1) pv1 = 1'b0;
        else if (pv1) pl1 = pl1 - 1;
        rdy = view;
        if (flush) begin
            // killed work never finishes, refetch from the oldest unissued
            pv0  = 1'b0;
            pv1  = 1'b0;
            rdy  = '1;
            fidx = exp_idx;
        end else begin
            if (eu0_en) begin
                strobes = strobes + 1;
                pv0 = 1'b1;
                pl0 = lat_of(eu0_slot.cls);
                prd0 = eu0_slot.rd;
                if (eu0_slot.rd != '0) rdy[eu0_slot.rd] = 1'b0;
                exp_idx = exp_idx + 1;
            end
            if (eu1_en) begin
                strobes = strobes + 1;
                pv1 = 1'b1;
                pl1 = lat_of(eu1_slot.cls);
                prd1 = eu1_slot.rd;
                if (eu1_slot.rd != '0) rdy[eu1_slot.rd] = 1'b0;
                exp_idx = exp_idx + 1;
            end
            fidx = fidx + int'(num_read);
            if (fidx > prog_end) fidx = prog_end;
        end
        if (cfg_we) ref_dual = cfg_dual;
    endtask

    task automatic run_program(input int p);
        logic done;
        logic first;
        logic flushed;
        prog_end = prog_start[p] + prog_len[p];
        exp_idx  = prog_start[p];
        fidx     = prog_start[p];
        first    = 1'b1;
        flushed  = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2;
            cfg_we   = first;
            cfg_dual = prog_dual[p];
            first    = 1'b0;
            flush    = (prog_flush[p] >= 0) && !flushed &&
                       (exp_idx - prog_start[p] >= prog_flush[p]);
            if (flush) flushed = 1'b1;
            fetch0 = (fidx < prog_end) ? tab[fidx] : '0;
            fetch1 = (fidx + 1 < prog_end) ? tab[fidx + 1] : '0;
            @(negedge clk);
            observe_cycle();
            done = (exp_idx == prog_end) && !pv0 && !pv1;
        end
        check_eq(128'(UUT.u_scoreboard.ready_mask), 128'(rdy), "registers left busy");
        check_eq(128'(issued_count), 128'(strobes), "issued_count");
    endtask

    initial begin
        void'($urandom(6625));
        arst_n = 1'b0;
        flush = 1'b0;
        cfg_we = 1'b0;
        cfg_dual = 1'b0;
        fetch0 = '0;
        fetch1 = '0;

        begin_prog(1'b1, -1);
        add_uop(1, 1, 2, 3);
        add_uop(1, 4, 5, 6);
        add_uop(1, 7, 1, 4);
        add_uop(2, 8, 7, 0);
        add_uop(1, 9, 8, 1);
        add_uop(1, 10, 2, 3);
        add_uop(0, 0, 0, 0);
        add_uop(1, 0, 1, 2);
        add_uop(1, 11, 0, 0);
        add_uop(2, 12, 1, 2);
        add_uop(1, 12, 3, 3);
        add_uop(1, 13, 12, 11);
        begin_prog(1'b0, -1);
        add_uop(1, 1, 2, 3);
        add_uop(1, 4, 5, 6);
        add_uop(1, 5, 2, 3);
        add_uop(1, 6, 7, 8);
        // mul in flight when the flush hits
        begin_prog(1'b1, 2);
        add_uop(2, 5, 1, 2);
        add_uop(1, 6, 1, 2);
        add_uop(2, 7, 5, 6);
        add_uop(1, 8, 7, 1);
        add_uop(1, 9, 2, 3);
        add_uop(1, 10, 9, 9);
        begin_prog(1'b1, -1);
        for (int i = 0; i < 16; i++) begin
            add_uop(int'($urandom % 3), int'($urandom % 8), int'($urandom % 8),
                    int'($urandom % 8));
        end
        for (int p = 0; p < nprog; p++) begin
            prog_len[p] = ((p + 1 < nprog) ? prog_start[p + 1] : ntab) - prog_start[p];
        end
        built = 1'b1;

        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_eq(128'(num_read), 128'(2), "num_read after reset");
        check_eq(128'(eu0_en || eu1_en || fin0 || fin1), 128'(0), "strobes after reset");
        check_eq(128'(issued_count), 128'(0), "issued_count after reset");

        for (int p = 0; p < nprog; p++) begin
            run_program(p);
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        wait (built);
        #((ntab * 40 + 100) * 20);
        $display("timeout: the issue stage did not finish the programs in time");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/issue_pkg.sv
design/issue_buffer.sv
design/issue_scoreboard.sv
design/issue_select.sv
design/issue_ctrl.sv
design/exec_unit.sv
design/issue_top.sv
test/issue_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the issue stage testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    -f build.f \
    --top-module issue_tb \
    -o issue_sim

./obj_dir/issue_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "run.sh: simulation ok"
else
    echo "run.sh: simulation did not pass"
    exit 1
fi
